/* compile.f */
rtl/fabric_pkg.sv
rtl/wait_state_timer.sv
rtl/sram_ctrl.sv
rtl/bus_txn_fsm.sv
rtl/sys_fabric_top.sv
dv/tb_sys_fabric.sv

/* dv/tb_sys_fabric.sv */
// directed testbench for the system bus slice, one transaction at a time
// external slave model acks after 0 to 3 idle cycles and returns addr ^ EXT_PATTERN
`timescale 1ns/1ps
`default_nettype none

module tb_sys_fabric
  import fabric_pkg::*;
();

  localparam int          TIMEOUT_CYCLES = 50;
  localparam logic [31:0] EXT_PATTERN    = 32'h5A5A_C3C3;
  localparam logic [15:0] LFSR_SEED      = 16'd53429;

  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [7:0]  id;
    resp_t       exp_resp;
    logic [31:0] exp_rdata;
    logic        ext_err;
    logic [3:0]  hold;
  } txn_case_t;

  logic      per_clk;
  logic      arst_n;
  aw_req_t   aw;
  w_req_t    w;
  ar_req_t   ar;
  logic      bready;
  logic      rready;
  ext_rsp_t  ext_rsp;
  logic      awready;
  logic      wready;
  logic      arready;
  b_rsp_t    b;
  r_rsp_t    r;
  ext_req_t  ext_req;

  txn_case_t cases[$];
  string     names[$];
  int        errors;
  int        tests_run;
  int        tests_failed;
  int        ext_rises;
  ext_req_t  ext_seen;
  logic      ext_err_mode;
  logic [15:0] lfsr;

  sys_fabric_top sys_fabric_top_i (
    .i_per_clk (per_clk),
    .i_arst_n  (arst_n),
    .i_aw      (aw),
    .i_w       (w),
    .i_ar      (ar),
    .i_bready  (bready),
    .i_rready  (rready),
    .i_ext     (ext_rsp),
    .o_awready (awready),
    .o_wready  (wready),
    .o_arready (arready),
    .o_b       (b),
    .o_r       (r),
    .o_ext     (ext_req)
  );

  always #10 per_clk = ~per_clk;

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic fail_value(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
    errors++;
  endtask

  task automatic fail_note(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  task automatic close_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s FAILED", name);
    end
  endtask

  task automatic add_case(input string name, input logic is_write, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [7:0] id, input resp_t exp_resp,
                          input logic [31:0] exp_rdata, input logic ext_err,
                          input logic [3:0] hold);
    names.push_back(name);
    cases.push_back('{is_write, addr, wdata, strb, id, exp_resp, exp_rdata, ext_err, hold});
  endtask

  // slave on the external port, one request at a time
  initial begin : ext_slave
    logic [1:0] idle_bits;
    int         k;
    ext_rsp = '0;
    lfsr    = LFSR_SEED;
    forever begin
      @(negedge per_clk);
      if (arst_n && ext_req.valid) begin
        ext_seen = ext_req;
        ext_rises++;
        idle_bits = '0;
        for (k = 0; k < 2; k++) begin
          lfsr      = lfsr_step(lfsr);
          idle_bits = {idle_bits[0], lfsr[0]};
        end
        for (k = 0; k < int'(idle_bits); k++) begin
          @(negedge per_clk);
          if (ext_req !== ext_seen) fail_note("external request changed while waiting for ack");
        end
        @(posedge per_clk);
        ext_rsp <= '{ack: 1'b1, err: ext_err_mode, data: ext_seen.addr ^ EXT_PATTERN};
        @(posedge per_clk);
        ext_rsp <= '0;
      end
    end
  end

  task automatic run_case(input string name, input txn_case_t tc);
    int         errs_at_start;
    int         rises_at_start;
    int         waited;
    int         edges;
    logic       seen;
    logic [3:0] region;
    b_rsp_t     b_got;
    r_rsp_t     r_got;
    errs_at_start  = errors;
    rises_at_start = ext_rises;
    region         = tc.addr[31:28];
    ext_err_mode   = tc.ext_err;
    @(posedge per_clk);
    if (tc.is_write) begin
      aw <= '{valid: 1'b1, addr: tc.addr, id: tc.id};
      w  <= '{valid: 1'b1, data: tc.wdata, strb: tc.strb};
    end else begin
      ar <= '{valid: 1'b1, addr: tc.addr, id: tc.id};
    end
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < TIMEOUT_CYCLES) begin
      @(negedge per_clk);
      seen = tc.is_write ? (awready && wready) : arready;
      waited++;
    end
    // accepting edge
    @(posedge per_clk);
    aw.valid <= 1'b0;
    w.valid  <= 1'b0;
    ar.valid <= 1'b0;
    if (!seen) begin
      fail_note($sformatf("%s: request not accepted within %0d cycles", name, TIMEOUT_CYCLES));
    end else begin
      seen  = 1'b0;
      edges = -1;
      while (!seen && edges < TIMEOUT_CYCLES) begin
        @(negedge per_clk);
        edges++;
        seen = tc.is_write ? b.valid : r.valid;
      end
      if (!seen) begin
        fail_note($sformatf("%s: no response within %0d cycles", name, TIMEOUT_CYCLES));
      end else begin
        b_got = b;
        r_got = r;
        if (region == REGION_MEM && edges != MEM_WAIT_CYCLES + 1) begin
          fail_value(name, "latency", 32'(MEM_WAIT_CYCLES + 1), 32'(edges));
        end
        // decode error answers from the accepting edge itself
        if (region != REGION_MEM && region != REGION_EXT && edges != 0) begin
          fail_value(name, "latency", 32'd0, 32'(edges));
        end
        if (tc.is_write) begin
          if (b_got.id !== tc.id) fail_value(name, "bid", 32'(tc.id), 32'(b_got.id));
          if (b_got.resp !== tc.exp_resp) begin
            fail_value(name, "bresp", 32'(tc.exp_resp), 32'(b_got.resp));
          end
        end else begin
          if (r_got.id !== tc.id) fail_value(name, "rid", 32'(tc.id), 32'(r_got.id));
          if (r_got.resp !== tc.exp_resp) begin
            fail_value(name, "rresp", 32'(tc.exp_resp), 32'(r_got.resp));
          end
          if (r_got.data !== tc.exp_rdata) fail_value(name, "rdata", tc.exp_rdata, r_got.data);
        end
        // back-pressure with a second read waiting
        for (int c = 0; c < int'(tc.hold); c++) begin
          @(posedge per_clk);
          if (!tc.is_write) ar <= '{valid: 1'b1, addr: tc.addr, id: tc.id + 8'd1};
          @(negedge per_clk);
          if (tc.is_write && b !== b_got) fail_note($sformatf("%s: o_b changed while held", name));
          if (!tc.is_write && r !== r_got) fail_note($sformatf("%s: o_r changed while held", name));
          if (awready || wready || arready) begin
            fail_note($sformatf("%s: a ready rose before the response was taken", name));
          end
        end
        @(posedge per_clk);
        bready   <= tc.is_write;
        rready   <= !tc.is_write;
        ar.valid <= 1'b0;
        @(posedge per_clk);
        bready <= 1'b0;
        rready <= 1'b0;
        @(negedge per_clk);
        if (b.valid || r.valid) fail_note($sformatf("%s: response still valid after ready", name));
      end
    end
    if (region == REGION_EXT) begin
      if (ext_rises != rises_at_start + 1) begin
        fail_value(name, "ext requests", 32'(rises_at_start + 1), 32'(ext_rises));
      end else begin
        if (ext_seen.we !== tc.is_write) fail_value(name, "ext we", 32'(tc.is_write), 32'(ext_seen.we));
        if (ext_seen.addr !== tc.addr) fail_value(name, "ext addr", tc.addr, ext_seen.addr);
        if (tc.is_write && ext_seen.data !== tc.wdata) begin
          fail_value(name, "ext data", tc.wdata, ext_seen.data);
        end
        if (tc.is_write && ext_seen.strb !== tc.strb) begin
          fail_value(name, "ext strb", 32'(tc.strb), 32'(ext_seen.strb));
        end
      end
    end else if (ext_rises != rises_at_start) begin
      fail_note($sformatf("%s: external port was requested", name));
    end
    close_test(name, errs_at_start);
  endtask

  initial begin : main
    int errs_at_start;
    per_clk      = 1'b0;
    arst_n       = 1'b0;
    aw           = '0;
    w            = '0;
    ar           = '0;
    bready       = 1'b0;
    rready       = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    ext_rises    = 0;
    ext_err_mode = 1'b0;

    //       name            wr    addr           wdata          strb   id     resp         rdata          err   hold
    add_case("mem_full_wr",  1'b1, 32'h0000_0040, 32'h1122_3344, 4'hF, 8'h11, RESP_OKAY,   32'h0,         1'b0, 4'd0);
    add_case("mem_part_wr",  1'b1, 32'h0000_0040, 32'hAABB_CCDD, 4'h5, 8'h12, RESP_OKAY,   32'h0,         1'b0, 4'd0);
    add_case("mem_rd_merge", 1'b0, 32'h0000_0040, 32'h0,         4'h0, 8'h13, RESP_OKAY,   32'h11BB_33DD, 1'b0, 4'd0);
    add_case("unmapped_wr",  1'b1, 32'h5000_0040, 32'hDEAD_BEEF, 4'hF, 8'h21, RESP_DECERR, 32'h0,         1'b0, 4'd0);
    add_case("unmapped_rd",  1'b0, 32'h5000_0040, 32'h0,         4'h0, 8'h22, RESP_DECERR, 32'h0,         1'b0, 4'd0);
    add_case("mem_rd_again", 1'b0, 32'h0000_0040, 32'h0,         4'h0, 8'h23, RESP_OKAY,   32'h11BB_33DD, 1'b0, 4'd0);
    add_case("ext_rd",       1'b0, 32'h1000_0010, 32'h0,         4'h0, 8'h31, RESP_OKAY,   32'h4A5A_C3D3, 1'b0, 4'd0);
    add_case("ext_wr",       1'b1, 32'h1000_0024, 32'hCAFE_F00D, 4'hC, 8'h32, RESP_OKAY,   32'h0,         1'b0, 4'd0);
    add_case("ext_wr_err",   1'b1, 32'h1000_0028, 32'h0102_0304, 4'hF, 8'h33, RESP_SLVERR, 32'h0,         1'b1, 4'd0);
    add_case("bp_wr",        1'b1, 32'h0000_0080, 32'h0BAD_CAFE, 4'hF, 8'h41, RESP_OKAY,   32'h0,         1'b0, 4'd10);
    add_case("bp_rd",        1'b0, 32'h0000_0080, 32'h0,         4'h0, 8'h42, RESP_OKAY,   32'h0BAD_CAFE, 1'b0, 4'd10);

    repeat (5) @(posedge per_clk);
    arst_n <= 1'b1;
    @(negedge per_clk);
    errs_at_start = errors;
    if (awready || wready || arready || b.valid || r.valid || ext_req.valid) begin
      fail_note("a valid or ready output is high after reset");
    end
    close_test("reset_state", errs_at_start);

    for (int i = 0; i < cases.size(); i++) begin
      run_case(names[i], cases[i]);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/bus_txn_fsm.sv */
// one transaction in flight at a time
// writes win over reads when both are valid
// address bits 31:28 pick memory, external port or the decode-error region
// response valid holds until the matching ready is sampled
`timescale 1ns/1ps
`default_nettype none

module bus_txn_fsm
  import fabric_pkg::*;
(
  input  logic                 i_per_clk,
  input  logic                 i_arst_n,
  input  aw_req_t              i_aw,
  input  w_req_t               i_w,
  input  ar_req_t              i_ar,
  input  logic                 i_bready,
  input  logic                 i_rready,
  input  ext_rsp_t             i_ext,
  input  logic                 i_wait_done,
  input  logic [DATA_W-1:0]    i_mem_rdata,
  output logic                 o_awready,
  output logic                 o_wready,
  output logic                 o_arready,
  output b_rsp_t               o_b,
  output r_rsp_t               o_r,
  output ext_req_t             o_ext,
  output logic                 o_wait_start,
  output logic                 o_mem_en,
  output logic                 o_mem_we,
  output logic [MEM_IDX_W-1:0] o_mem_idx,
  output logic [DATA_W-1:0]    o_mem_wdata,
  output logic [STRB_W-1:0]    o_mem_strb
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MEM_WAIT,
    ST_EXT_WAIT,
    ST_RESP_WR,
    ST_RESP_RD
  } state_t;

  state_t              state_q;
  state_t              state_d;
  logic                wr_go;
  logic                rd_go;
  logic                accept;
  logic [ADDR_W-1:0]   acc_addr;
  logic [REGION_W-1:0] acc_region;
  logic                we_q;
  logic                rd_mem_q;
  resp_t               resp_q;
  logic [ADDR_W-1:0]   addr_q;
  logic [DATA_W-1:0]   data_q;
  logic [STRB_W-1:0]   strb_q;
  logic [ID_W-1:0]     id_q;
  logic [DATA_W-1:0]   rdata_q;

  assign wr_go      = (state_q == ST_IDLE) && i_aw.valid && i_w.valid;
  assign rd_go      = (state_q == ST_IDLE) && i_ar.valid && !(i_aw.valid && i_w.valid);
  assign accept     = wr_go || rd_go;
  assign acc_addr   = wr_go ? i_aw.addr : i_ar.addr;
  assign acc_region = acc_addr[ADDR_W-1 -: REGION_W];

  assign o_awready    = wr_go;
  assign o_wready     = wr_go;
  assign o_arready    = rd_go;
  // timer starts on the accepting edge itself
  assign o_wait_start = accept && (acc_region == REGION_MEM);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          if (acc_region == REGION_MEM) begin
            state_d = ST_MEM_WAIT;
          end else if (acc_region == REGION_EXT) begin
            state_d = ST_EXT_WAIT;
          end else begin
            state_d = wr_go ? ST_RESP_WR : ST_RESP_RD;
          end
        end
      end
      ST_MEM_WAIT: if (i_wait_done) state_d = we_q ? ST_RESP_WR : ST_RESP_RD;
      ST_EXT_WAIT: if (i_ext.ack) state_d = we_q ? ST_RESP_WR : ST_RESP_RD;
      ST_RESP_WR:  if (i_bready) state_d = ST_IDLE;
      ST_RESP_RD:  if (i_rready) state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= ST_IDLE;
      we_q     <= 1'b0;
      rd_mem_q <= 1'b0;
      resp_q   <= RESP_OKAY;
    end else begin
      state_q <= state_d;
      if (accept) begin
        we_q     <= wr_go;
        rd_mem_q <= 1'b0;
        if (acc_region == REGION_MEM || acc_region == REGION_EXT) begin
          resp_q <= RESP_OKAY;
        end else begin
          resp_q <= RESP_DECERR;
        end
      end
      // memory read data is registered by the sram on this same edge
      if (state_q == ST_MEM_WAIT && i_wait_done) rd_mem_q <= !we_q;
      if (state_q == ST_EXT_WAIT && i_ext.ack) begin
        resp_q <= i_ext.err ? RESP_SLVERR : RESP_OKAY;
      end
    end
  end

  always_ff @(posedge i_per_clk) begin
    if (accept) begin
      addr_q  <= acc_addr;
      id_q    <= wr_go ? i_aw.id : i_ar.id;
      data_q  <= wr_go ? i_w.data : '0;
      strb_q  <= wr_go ? i_w.strb : '0;
      rdata_q <= '0;
    end
    if (state_q == ST_EXT_WAIT && i_ext.ack) rdata_q <= i_ext.data;
  end

  assign o_mem_en    = (state_q == ST_MEM_WAIT) && i_wait_done;
  assign o_mem_we    = we_q;
  assign o_mem_idx   = addr_q[MEM_IDX_W+1:2];
  assign o_mem_wdata = data_q;
  assign o_mem_strb  = strb_q;

  assign o_ext = '{valid: (state_q == ST_EXT_WAIT), we: we_q, addr: addr_q,
                   data: data_q, strb: strb_q};

  assign o_b = '{valid: (state_q == ST_RESP_WR), id: id_q, resp: resp_q};
  assign o_r = '{valid: (state_q == ST_RESP_RD), id: id_q,
                 data: rd_mem_q ? i_mem_rdata : rdata_q, resp: resp_q};

  a_b_hold: assert property (@(posedge i_per_clk) disable iff (!i_arst_n)
    (o_b.valid && !i_bready) |=> (o_b.valid && $stable(o_b)))
    else $error("write response changed under back-pressure");

  // read data comes straight from the sram output register
  a_r_hold: assert property (@(posedge i_per_clk) disable iff (!i_arst_n)
    (o_r.valid && !i_rready) |=> (o_r.valid && $stable(o_r)))
    else $error("read response changed under back-pressure");

endmodule

`default_nettype wire

/* rtl/fabric_pkg.sv */
// shared widths, address map and channel structs for the system bus slice
// single-beat transfers only, no bursts or cache/protection attributes
`default_nettype none

package fabric_pkg;

  localparam int ADDR_W          = 32;
  localparam int DATA_W          = 32;
  localparam int STRB_W          = DATA_W / 8;
  localparam int ID_W            = 8;
  localparam int MEM_IDX_W       = 8;
  // must be at least 1
  localparam int MEM_WAIT_CYCLES = 2;
  localparam int WAIT_CNT_W      = $clog2(MEM_WAIT_CYCLES + 1);

  // region select taken from the top address nibble
  localparam int REGION_W                 = 4;
  localparam logic [REGION_W-1:0] REGION_MEM = 4'h0;
  localparam logic [REGION_W-1:0] REGION_EXT = 4'h1;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } aw_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_req_t;

  typedef struct packed {
    logic            valid;
    logic [ID_W-1:0] id;
    resp_t           resp;
  } b_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } ar_req_t;

  typedef struct packed {
    logic              valid;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_t             resp;
  } r_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } ext_req_t;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] data;
  } ext_rsp_t;

endpackage

`default_nettype wire

/* rtl/sram_ctrl.sv */
// 256 x 32 word memory, word index from address bits 9:2
// no reset, contents are undefined until written
// read data is registered and holds until the next enabled read
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl
  import fabric_pkg::*;
(
  input  logic                 i_per_clk,
  input  logic                 i_en,
  input  logic                 i_we,
  input  logic [MEM_IDX_W-1:0] i_idx,
  input  logic [DATA_W-1:0]    i_wdata,
  input  logic [STRB_W-1:0]    i_strb,
  output logic [DATA_W-1:0]    o_rdata
);

  localparam int DEPTH = 1 << MEM_IDX_W;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DATA_W-1:0] rdata_q;

  always_ff @(posedge i_per_clk) begin
    if (i_en) begin
      if (i_we) begin
        // byte lanes outside the strobe keep their old value
        for (int b = 0; b < STRB_W; b++) begin
          if (i_strb[b]) begin
            mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[i_idx];
      end
    end
  end

  assign o_rdata = rdata_q;

  a_strb_nonzero: assert property (@(posedge i_per_clk)
    (i_en && i_we) |-> (i_strb != '0))
    else $error("memory write with empty strobe");

endmodule

`default_nettype wire

/* rtl/sys_fabric_top.sv */
// system bus slice: master port to on-chip memory, external port or decode error
// region 0 is memory, region 1 the external slave, anything else answers DECERR
`timescale 1ns/1ps
`default_nettype none

module sys_fabric_top
  import fabric_pkg::*;
(
  input  logic     i_per_clk,
  input  logic     i_arst_n,
  input  aw_req_t  i_aw,
  input  w_req_t   i_w,
  input  ar_req_t  i_ar,
  input  logic     i_bready,
  input  logic     i_rready,
  input  ext_rsp_t i_ext,
  output logic     o_awready,
  output logic     o_wready,
  output logic     o_arready,
  output b_rsp_t   o_b,
  output r_rsp_t   o_r,
  output ext_req_t o_ext
);

  logic                 wait_start;
  logic                 wait_done;
  logic                 mem_en;
  logic                 mem_we;
  logic [MEM_IDX_W-1:0] mem_idx;
  logic [DATA_W-1:0]    mem_wdata;
  logic [STRB_W-1:0]    mem_strb;
  logic [DATA_W-1:0]    mem_rdata;

  bus_txn_fsm bus_txn_fsm_i (
    .i_per_clk    (i_per_clk),
    .i_arst_n     (i_arst_n),
    .i_aw         (i_aw),
    .i_w          (i_w),
    .i_ar         (i_ar),
    .i_bready     (i_bready),
    .i_rready     (i_rready),
    .i_ext        (i_ext),
    .i_wait_done  (wait_done),
    .i_mem_rdata  (mem_rdata),
    .o_awready    (o_awready),
    .o_wready     (o_wready),
    .o_arready    (o_arready),
    .o_b          (o_b),
    .o_r          (o_r),
    .o_ext        (o_ext),
    .o_wait_start (wait_start),
    .o_mem_en     (mem_en),
    .o_mem_we     (mem_we),
    .o_mem_idx    (mem_idx),
    .o_mem_wdata  (mem_wdata),
    .o_mem_strb   (mem_strb)
  );

  wait_state_timer wait_state_timer_i (
    .i_per_clk (i_per_clk),
    .i_arst_n  (i_arst_n),
    .i_start   (wait_start),
    .o_done    (wait_done)
  );

  sram_ctrl sram_ctrl_i (
    .i_per_clk (i_per_clk),
    .i_en      (mem_en),
    .i_we      (mem_we),
    .i_idx     (mem_idx),
    .i_wdata   (mem_wdata),
    .i_strb    (mem_strb),
    .o_rdata   (mem_rdata)
  );

endmodule

`default_nettype wire

/* rtl/wait_state_timer.sv */
// fixed wait-state delay for memory accesses, MEM_WAIT_CYCLES must be at least 1
// a new start is only legal once the previous count has expired
`timescale 1ns/1ps
`default_nettype none

module wait_state_timer
  import fabric_pkg::*;
(
  input  logic i_per_clk,
  input  logic i_arst_n,
  input  logic i_start,
  output logic o_done
);

  logic [WAIT_CNT_W-1:0] cnt_q;
  logic                  done_q;

  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      // last count step raises done for one cycle
      done_q <= (cnt_q == WAIT_CNT_W'(1));
      if (i_start) begin
        cnt_q <= WAIT_CNT_W'(MEM_WAIT_CYCLES);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign o_done = done_q;

  a_no_restart: assert property (@(posedge i_per_clk) disable iff (!i_arst_n)
    i_start |-> (cnt_q == '0 && !done_q))
    else $error("timer restarted while counting");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the system bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_sys_fabric \
  -f compile.f -o tb_sys_fabric_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_sys_fabric_sim)
echo "$sim_out"

grep -qx "PASS: all tests" <<< "$sim_out" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
